// ==== vlog.f ====
design/dram_ctrl_pkg.sv
design/display_pkg.sv
design/load_tracker.sv
design/traffic_arbiter.sv
design/seven_segment_controller.sv
design/dram_traffic_top.sv
test/wb_mem_model.sv
test/tb_dram_traffic.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_dram_traffic -f vlog.f -o Vtb_dram_traffic

./obj_dir/Vtb_dram_traffic > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== test/tb_dram_traffic.sv ====
module tb_dram_traffic;
    timeunit 1ns;
    timeprecision 1ps;

    import dram_ctrl_pkg::*;
    import display_pkg::*;

    localparam int SCAN_CYCLES    = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_WR         = 6;
    localparam int NUM_RD         = 6;
    // 12 transfers of about 10 clocks, then the display scan and margin
    localparam int TIMEOUT_CYCLES = (NUM_WR + NUM_RD) * 10 + 280;

    logic      clk_dram_ctrl;
    logic      rst_dram_ctrl;
    logic      i_wr_valid;
    mem_data_t i_wr_data;
    logic      i_wr_last;
    logic      o_wr_ready;
    logic      i_rd_valid;
    mem_addr_t i_rd_addr;
    logic      o_rd_ready;
    logic      o_rd_data_valid;
    mem_data_t o_rd_data;
    logic      i_rd_data_ready;
    logic      o_wb_cyc;
    logic      o_wb_stb;
    logic      o_wb_we;
    mem_addr_t o_wb_adr;
    mem_data_t o_wb_dat;
    wb_sel_t   o_wb_sel;
    logic      i_wb_ack;
    mem_data_t i_wb_dat;
    logic      o_sample_load_complete;
    anode_t    o_ss_an;
    seg_t      o_ss_c;

    // stimulus table and the data each read must return
    mem_data_t wr_words [NUM_WR];
    mem_addr_t rd_addrs [NUM_RD];
    mem_data_t rd_expect [NUM_RD];

    int        errors       = 0;
    int        cycles       = 0;
    int        bus_idx      = 0;
    int        writes_acked = 0;
    int        rd_idx       = 0;
    logic      held         = 1'b0;
    mem_data_t held_data;
    integer    stall_seed   = 32'h926897a9;

    dram_traffic_top #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) UUT (.*);

    wb_mem_model u_mem (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_wb_cyc      (o_wb_cyc),
        .i_wb_stb      (o_wb_stb),
        .i_wb_we       (o_wb_we),
        .i_wb_adr      (o_wb_adr),
        .i_wb_dat      (o_wb_dat),
        .i_wb_sel      (o_wb_sel),
        .o_wb_ack      (i_wb_ack),
        .o_wb_dat      (i_wb_dat)
    );

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // lit segments of each hex digit
    function automatic string segment_letters(input nibble_t n);
        case (n)
            4'h0: return "abcdef";
            4'h1: return "bc";
            4'h2: return "abdeg";
            4'h3: return "abcdg";
            4'h4: return "bcfg";
            4'h5: return "acdfg";
            4'h6: return "acdefg";
            4'h7: return "abc";
            4'h8: return "abcdefg";
            4'h9: return "abcdfg";
            4'hA: return "abcefg";
            4'hB: return "cdefg";
            4'hC: return "adef";
            4'hD: return "bcdeg";
            4'hE: return "adefg";
            default: return "aefg";
        endcase
    endfunction

    function automatic seg_t expected_segments(input nibble_t n);
        string lit;
        seg_t  segs;
        lit  = segment_letters(n);
        segs = '1;
        for (int i = 0; i < lit.len(); i++) segs[lit[i] - "a"] = 1'b0;  // active low
        return segs;
    endfunction

    task automatic load_stimulus_table();
        wr_words[0] = 128'h00112233_44556677_8899aabb_ccddeeff;
        wr_words[1] = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;
        wr_words[2] = 128'hdeadbeef_cafef00d_01234567_89abcdef;
        wr_words[3] = 128'h13579bdf_2468ace0_fedcba98_76543210;
        wr_words[4] = 128'ha5a5a5a5_5a5a5a5a_c3c3c3c3_3c3c3c3c;
        wr_words[5] = 128'h80000001_7ffffffe_00ff00ff_ff00ff00;
        rd_addrs    = '{24'd3, 24'd0, 24'd5, 24'd1, 24'd4, 24'd2};
        for (int i = 0; i < NUM_RD; i++) rd_expect[i] = wr_words[rd_addrs[i]];  // beat n at n
    endtask

    // ready only moves on rising edges, so its falling-edge value decides the transfer
    task automatic send_write(input mem_data_t data, input logic last);
        i_wr_valid = 1'b1;
        i_wr_data  = data;
        i_wr_last  = last;
        while (!o_wr_ready) @(negedge clk_dram_ctrl);
        @(negedge clk_dram_ctrl);
        i_wr_valid = 1'b0;
    endtask

    task automatic send_read(input mem_addr_t addr);
        i_rd_valid = 1'b1;
        i_rd_addr  = addr;
        while (!o_rd_ready) @(negedge clk_dram_ctrl);
        @(negedge clk_dram_ctrl);
        i_rd_valid = 1'b0;
    endtask

    task automatic check_display();
        disp_val_t shown;
        anode_t    seen;
        shown = disp_val_t'(NUM_WR + NUM_RD);
        seen  = '0;
        repeat (SCAN_CYCLES * NUM_DIGITS + 8) begin
            @(negedge clk_dram_ctrl);
            if ($countones(~o_ss_an) > 1) begin
                errors++;
                $display("more than one digit lit at %0t: anodes %b", $time, o_ss_an);
            end
            for (int k = 0; k < NUM_DIGITS; k++) begin
                if (!o_ss_an[k]) begin
                    seen[k] = 1'b1;
                    check_value($sformatf("o_ss_c digit %0d", k), o_ss_c,
                                expected_segments(shown[k*4 +: 4]));
                end
            end
        end
        if (seen != '1) begin
            errors++;
            $display("not every digit was scanned: seen %b", seen);
        end
    endtask

    initial begin
        clk_dram_ctrl = 1'b0;
        forever #5 clk_dram_ctrl = ~clk_dram_ctrl;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_dram_ctrl);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // random back-pressure on the read-data stream
    initial begin
        i_rd_data_ready = 1'b0;
        forever begin
            @(negedge clk_dram_ctrl);
            i_rd_data_ready = ($random(stall_seed) & 3) != 0;
        end
    end

    // flags and bus cycles, sampled before the edge updates them
    always @(posedge clk_dram_ctrl) begin : bus_monitor
        mem_addr_t exp_adr;
        if (!rst_dram_ctrl) begin
            check_value("o_sample_load_complete", o_sample_load_complete,
                        writes_acked == NUM_WR);
            if (!o_sample_load_complete) check_value("o_rd_ready", o_rd_ready, 1'b0);
            else check_value("o_wr_ready", o_wr_ready, 1'b0);
            if (o_wb_cyc && i_wb_ack && bus_idx >= NUM_WR + NUM_RD) begin
                errors++;
                $display("unexpected bus cycle at %0t", $time);
            end else if (o_wb_cyc && i_wb_ack) begin
                exp_adr = (bus_idx < NUM_WR) ? mem_addr_t'(bus_idx) : rd_addrs[bus_idx - NUM_WR];
                check_value("o_wb_stb", o_wb_stb, 1'b1);
                check_value("o_wb_we", o_wb_we, bus_idx < NUM_WR);
                check_value("o_wb_adr", o_wb_adr, exp_adr);
                check_value("o_wb_sel", o_wb_sel, {WB_SEL_W{1'b1}});
                if (bus_idx < NUM_WR) begin
                    check_value("o_wb_dat", o_wb_dat, wr_words[bus_idx]);
                    writes_acked++;
                end
                bus_idx++;
            end
        end
    end

    always @(posedge clk_dram_ctrl) begin
        if (!rst_dram_ctrl) begin
            if (held) begin                         // stalled item must not move
                check_value("o_rd_data_valid", o_rd_data_valid, 1'b1);
                check_value("o_rd_data held", o_rd_data, held_data);
            end
            if (o_rd_data_valid && i_rd_data_ready && rd_idx >= NUM_RD) begin
                errors++;
                $display("read data with no request outstanding at %0t", $time);
            end else if (o_rd_data_valid && i_rd_data_ready) begin
                check_value("o_rd_data", o_rd_data, rd_expect[rd_idx]);
                rd_idx++;
            end
            held      = o_rd_data_valid && !i_rd_data_ready;
            held_data = o_rd_data;
        end
    end

    initial begin
        rst_dram_ctrl = 1'b1;
        i_wr_valid    = 1'b0;
        i_wr_data     = '0;
        i_wr_last     = 1'b0;
        i_rd_valid    = 1'b0;
        i_rd_addr     = '0;
        load_stimulus_table();
        repeat (RESET_CYCLES) @(negedge clk_dram_ctrl);
        check_value("o_wb_cyc", o_wb_cyc, 1'b0);
        check_value("o_wr_ready", o_wr_ready, 1'b0);
        check_value("o_rd_ready", o_rd_ready, 1'b0);
        check_value("o_rd_data_valid", o_rd_data_valid, 1'b0);
        check_value("o_sample_load_complete", o_sample_load_complete, 1'b0);
        check_value("o_ss_an", o_ss_an, {NUM_DIGITS{1'b1}});
        rst_dram_ctrl = 1'b0;
        i_rd_valid = 1'b1;                          // first read waits out the load
        i_rd_addr  = rd_addrs[0];
        for (int i = 0; i < NUM_WR; i++) send_write(wr_words[i], i == NUM_WR - 1);
        for (int i = 0; i < NUM_RD; i++) send_read(rd_addrs[i]);
        while (rd_idx < NUM_RD) @(negedge clk_dram_ctrl);
        check_value("bus cycles", bus_idx, NUM_WR + NUM_RD);
        check_display();
        $display("checks done at %0t, errors: %0d", $time, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== test/wb_mem_model.sv ====
module wb_mem_model (
    input  logic                      clk_dram_ctrl,
    input  logic                      rst_dram_ctrl,
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  dram_ctrl_pkg::mem_addr_t  i_wb_adr,
    input  dram_ctrl_pkg::mem_data_t  i_wb_dat,
    input  dram_ctrl_pkg::wb_sel_t    i_wb_sel,
    output logic                      o_wb_ack,
    output dram_ctrl_pkg::mem_data_t  o_wb_dat
);
    timeunit 1ns;
    timeprecision 1ps;

    import dram_ctrl_pkg::*;

    mem_data_t mem [mem_addr_t];        // only written bursts exist
    logic      busy;
    int        wait_cnt;
    integer    delay_seed = 32'h926897a9;

    always @(posedge clk_dram_ctrl) begin : slave
        mem_data_t word;
        if (rst_dram_ctrl) begin
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
            busy     <= 1'b0;
            wait_cnt <= 0;
        end else if (o_wb_ack) begin
            o_wb_ack <= 1'b0;           // master ends the cycle on this edge
        end else if (busy) begin
            if (wait_cnt == 0) begin
                o_wb_ack <= 1'b1;
                busy     <= 1'b0;
                word = mem.exists(i_wb_adr) ? mem[i_wb_adr] : '0;
                if (i_wb_we) begin
                    for (int b = 0; b < WB_SEL_W; b++) begin
                        if (i_wb_sel[b]) word[b*8 +: 8] = i_wb_dat[b*8 +: 8];
                    end
                    mem[i_wb_adr] = word;
                end else begin
                    o_wb_dat <= word;   // read data in the ack cycle
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (i_wb_cyc && i_wb_stb) begin
            busy     <= 1'b1;
            wait_cnt <= $random(delay_seed) & 3;    // 1 to 4 clocks to ack
        end
    end

endmodule

// ==== design/dram_traffic_top.sv ====
module dram_traffic_top #(
    parameter int SCAN_CYCLES = 1000
) (
    input  logic                      clk_dram_ctrl,
    input  logic                      rst_dram_ctrl,
    input  logic                      i_wr_valid,
    input  dram_ctrl_pkg::mem_data_t  i_wr_data,
    input  logic                      i_wr_last,
    output logic                      o_wr_ready,
    input  logic                      i_rd_valid,
    input  dram_ctrl_pkg::mem_addr_t  i_rd_addr,
    output logic                      o_rd_ready,
    output logic                      o_rd_data_valid,
    output dram_ctrl_pkg::mem_data_t  o_rd_data,
    input  logic                      i_rd_data_ready,
    output logic                      o_wb_cyc,
    output logic                      o_wb_stb,
    output logic                      o_wb_we,
    output dram_ctrl_pkg::mem_addr_t  o_wb_adr,
    output dram_ctrl_pkg::mem_data_t  o_wb_dat,
    output dram_ctrl_pkg::wb_sel_t    o_wb_sel,
    input  logic                      i_wb_ack,
    input  dram_ctrl_pkg::mem_data_t  i_wb_dat,
    output logic                      o_sample_load_complete,
    output display_pkg::anode_t       o_ss_an,
    output display_pkg::seg_t         o_ss_c
);

    import dram_ctrl_pkg::*;
    import display_pkg::*;

    logic       wr_done;
    logic       wr_last_done;
    mem_addr_t  wr_addr;
    req_count_t req_count;
    disp_val_t  disp_val;

    // low 16 bits of the request count
    assign disp_val = {16'h0000, req_count[15:0]};

    load_tracker u_load_tracker (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_wr_done       (wr_done),
        .i_wr_last       (wr_last_done),
        .o_wr_addr       (wr_addr),
        .o_load_complete (o_sample_load_complete)
    );

    traffic_arbiter u_traffic_arbiter (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_wr_valid      (i_wr_valid),
        .i_wr_data       (i_wr_data),
        .i_wr_last       (i_wr_last),
        .o_wr_ready      (o_wr_ready),
        .i_rd_valid      (i_rd_valid),
        .i_rd_addr       (i_rd_addr),
        .o_rd_ready      (o_rd_ready),
        .o_rd_data_valid (o_rd_data_valid),
        .o_rd_data       (o_rd_data),
        .i_rd_data_ready (i_rd_data_ready),
        .o_wb_cyc        (o_wb_cyc),
        .o_wb_stb        (o_wb_stb),
        .o_wb_we         (o_wb_we),
        .o_wb_adr        (o_wb_adr),
        .o_wb_dat        (o_wb_dat),
        .o_wb_sel        (o_wb_sel),
        .i_wb_ack        (i_wb_ack),
        .i_wb_dat        (i_wb_dat),
        .i_wr_addr       (wr_addr),
        .i_load_complete (o_sample_load_complete),
        .o_wr_done       (wr_done),
        .o_wr_last_done  (wr_last_done),
        .o_req_count     (req_count)
    );

    seven_segment_controller #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) u_seven_segment_controller (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_val         (disp_val),
        .o_ss_an       (o_ss_an),
        .o_ss_c        (o_ss_c)
    );

endmodule

// ==== design/seven_segment_controller.sv ====
module seven_segment_controller #(
    parameter int SCAN_CYCLES = 1000    // clocks per lit digit
) (
    input  logic                  clk_dram_ctrl,
    input  logic                  rst_dram_ctrl,
    input  display_pkg::disp_val_t i_val,
    output display_pkg::anode_t    o_ss_an,
    output display_pkg::seg_t      o_ss_c
);

    import display_pkg::*;

    localparam int SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

    logic [SCAN_W-1:0] scan_cnt;
    digit_idx_t        digit;
    nibble_t           nibble;

    // hex digit to active-low segments, g down to a
    function automatic seg_t hex_to_seg(input nibble_t n);
        logic [6:0] lit;
        case (n)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    assign nibble = i_val[digit*4 +: 4];

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            scan_cnt <= '0;
            digit    <= '0;
        end else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1)) begin
            scan_cnt <= '0;
            digit    <= digit + 1'b1;    // wraps after digit 7
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // anode and cathode change on the same edge
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_ss_an <= '1;
            o_ss_c  <= SEG_BLANK;
        end else begin
            o_ss_an <= ~(anode_t'(1) << digit);
            o_ss_c  <= hex_to_seg(nibble);
        end
    end

    a_one_digit_lit: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        $onehot0(~o_ss_an)
    );

endmodule

// ==== design/traffic_arbiter.sv ====
module traffic_arbiter (
    input  logic                       clk_dram_ctrl,
    input  logic                       rst_dram_ctrl,

    // sample-load write stream
    input  logic                       i_wr_valid,
    input  dram_ctrl_pkg::mem_data_t   i_wr_data,
    input  logic                       i_wr_last,
    output logic                       o_wr_ready,

    // audio read requests and their data
    input  logic                       i_rd_valid,
    input  dram_ctrl_pkg::mem_addr_t   i_rd_addr,
    output logic                       o_rd_ready,
    output logic                       o_rd_data_valid,
    output dram_ctrl_pkg::mem_data_t   o_rd_data,
    input  logic                       i_rd_data_ready,

    // wishbone classic master
    output logic                       o_wb_cyc,
    output logic                       o_wb_stb,
    output logic                       o_wb_we,
    output dram_ctrl_pkg::mem_addr_t   o_wb_adr,
    output dram_ctrl_pkg::mem_data_t   o_wb_dat,
    output dram_ctrl_pkg::wb_sel_t     o_wb_sel,
    input  logic                       i_wb_ack,
    input  dram_ctrl_pkg::mem_data_t   i_wb_dat,

    input  dram_ctrl_pkg::mem_addr_t   i_wr_addr,       // next burst for the load
    input  logic                       i_load_complete,
    output logic                       o_wr_done,
    output logic                       o_wr_last_done,
    output dram_ctrl_pkg::req_count_t  o_req_count
);

    import dram_ctrl_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_RESPOND
    } state_t;

    state_t state;
    logic   wr_accept;
    logic   rd_accept;
    logic   wr_last_q;    // beat on the bus is the final one

    // ready is only ever high in idle
    assign wr_accept = o_wr_ready && i_wr_valid;
    assign rd_accept = o_rd_ready && i_rd_valid;

    assign o_wb_sel       = WB_SEL_FULL;
    assign o_wr_done      = o_wb_cyc && o_wb_we && i_wb_ack;
    assign o_wr_last_done = o_wr_done && wr_last_q;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            state           <= ST_IDLE;
            o_wr_ready      <= 1'b0;
            o_rd_ready      <= 1'b0;
            o_wb_cyc        <= 1'b0;
            o_wb_stb        <= 1'b0;
            o_rd_data_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_accept) begin
                        o_wr_ready <= 1'b0;
                        o_wb_cyc   <= 1'b1;
                        o_wb_stb   <= 1'b1;
                        state      <= ST_WRITE;
                    end else if (rd_accept) begin
                        o_rd_ready <= 1'b0;
                        o_wb_cyc   <= 1'b1;
                        o_wb_stb   <= 1'b1;
                        state      <= ST_READ;
                    end else begin
                        // writes until the load is in, reads after
                        o_wr_ready <= !i_load_complete;
                        o_rd_ready <= i_load_complete;
                    end
                end
                ST_WRITE, ST_READ: begin
                    if (i_wb_ack) begin
                        o_wb_cyc <= 1'b0;   // bus idles the clock after ack
                        o_wb_stb <= 1'b0;
                        if (state == ST_READ) begin
                            o_rd_data_valid <= 1'b1;
                            state           <= ST_RESPOND;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_RESPOND: begin
                    if (i_rd_data_ready) begin
                        o_rd_data_valid <= 1'b0;
                        state           <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request latched at stream transfer, held through the bus cycle
    always_ff @(posedge clk_dram_ctrl) begin
        if (wr_accept) begin
            o_wb_we   <= 1'b1;
            o_wb_adr  <= i_wr_addr;
            o_wb_dat  <= i_wr_data;
            wr_last_q <= i_wr_last;
        end else if (rd_accept) begin
            o_wb_we  <= 1'b0;
            o_wb_adr <= i_rd_addr;
        end
        if (state == ST_READ && i_wb_ack) begin
            o_rd_data <= i_wb_dat;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_req_count <= '0;
        end else if (o_wb_cyc && i_wb_ack) begin
            o_req_count <= o_req_count + 1'b1;
        end
    end

    a_stb_is_cyc: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_wb_stb == o_wb_cyc
    );

    // classic cycle is held until the slave answers
    a_cyc_held: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (o_wb_cyc && !i_wb_ack) |=> o_wb_cyc
    );

    a_no_early_read: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        rd_accept |-> i_load_complete
    );

endmodule

// ==== design/load_tracker.sv ====
module load_tracker (
    input  logic                    clk_dram_ctrl,
    input  logic                    rst_dram_ctrl,
    input  logic                    i_wr_done,        // one pulse per write ack
    input  logic                    i_wr_last,        // that write was the last beat
    output dram_ctrl_pkg::mem_addr_t o_wr_addr,
    output logic                    o_load_complete
);

    // sample words land at consecutive bursts from address 0
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_wr_addr <= '0;
        end else if (i_wr_done) begin
            o_wr_addr <= o_wr_addr + 1'b1;
        end
    end

    // sticky until the next reset
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_load_complete <= 1'b0;
        end else if (i_wr_done && i_wr_last) begin
            o_load_complete <= 1'b1;
        end
    end

    // the arbiter closes the write phase once the last beat is in
    a_no_write_after_load: assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        i_wr_done |-> !o_load_complete
    );

endmodule

// ==== design/display_pkg.sv ====
package display_pkg;

    localparam int NUM_DIGITS = 8;
    localparam int DIGIT_W    = $clog2(NUM_DIGITS);

    typedef logic [31:0] disp_val_t;           // eight hex digits
    typedef logic [3:0]  nibble_t;
    typedef logic [6:0]  seg_t;                // g down to a, active low
    typedef logic [NUM_DIGITS-1:0] anode_t;    // active low
    typedef logic [DIGIT_W-1:0]    digit_idx_t;

    // all segments dark
    localparam seg_t SEG_BLANK = '1;

endpackage

// ==== design/dram_ctrl_pkg.sv ====
package dram_ctrl_pkg;

    // widths on the memory side of the core
    localparam int MEM_ADDR_W  = 24;                 // burst address
    localparam int MEM_DATA_W  = 128;                // one burst word
    localparam int WB_SEL_W    = MEM_DATA_W / 8;     // one select bit per byte
    localparam int REQ_COUNT_W = 24;

    // burst-addressable location in external memory
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // a full memory word, as carried on the streams and the bus
    typedef logic [MEM_DATA_W-1:0] mem_data_t;

    typedef logic [WB_SEL_W-1:0] wb_sel_t;

    // completed bus requests, reads and writes together
    typedef logic [REQ_COUNT_W-1:0] req_count_t;

    // whole words only, no partial writes
    localparam wb_sel_t WB_SEL_FULL = '1;

endpackage
